//--- vlog.f
logic/systolic_pkg.sv
logic/input_skew_fifo.sv
logic/partial_sum_fifo.sv
logic/mac_grid.sv
logic/result_stage.sv
logic/array_control.sv
logic/systolic_array.sv
test/systolic_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module systolic_array_tb --Mdir obj_dir -o systolic_array_tb_sim \
  && ./obj_dir/systolic_array_tb_sim | tee /dev/stderr | grep -qx "STATUS: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- test/systolic_array_tb.sv
`timescale 1ns/1ps

module systolic_array_tb;
    localparam int N            = systolic_pkg::ARRAY_DIM;
    localparam int IDX_W        = systolic_pkg::ROW_IDX_W;
    localparam int RUN_CYCLES   = systolic_pkg::RUN_CYCLES;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int RUN_COUNT    = 7;
    // Two cycles per row load for three matrices, then the run and the reads
    localparam int RUN_LENGTH   = 2 * 3 * N + RUN_CYCLES + 2 + 2 * N;
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * N + RUN_COUNT * RUN_LENGTH;
    localparam int DONE_LIMIT   = 2 * RUN_CYCLES;

    logic                    clk;
    logic                    nRST;
    systolic_pkg::mem_load_t mem_load;
    logic                    start;
    logic [IDX_W-1:0]        result_row;
    logic                    busy;
    logic                    done;
    systolic_pkg::row_t      result_data;

    // Matrices as the memory side sees them, and the expected result
    systolic_pkg::elem_t a_mat [N][N];
    systolic_pkg::elem_t w_mat [N][N];
    systolic_pkg::elem_t p_mat [N][N];
    systolic_pkg::elem_t c_mat [N][N];

    logic [31:0] rng_state;
    int          mismatch_errors;
    int          protocol_errors;
    int          row_reads;

    systolic_array u_systolic_array (
        .clk         (clk),
        .nRST        (nRST),
        .mem_load    (mem_load),
        .start       (start),
        .result_row  (result_row),
        .busy        (busy),
        .done        (done),
        .result_data (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

    a_idle_after_reset: assert property (@(posedge clk) $rose(nRST) |-> !busy && !done)
        else begin
            protocol_errors++;
            $display("busy or done is high right after reset");
        end

    a_start_busy: assert property (@(posedge clk) disable iff (!nRST)
        start && !busy |=> busy)
        else begin
            protocol_errors++;
            $display("busy did not rise one cycle after start");
        end

    a_done_timing: assert property (@(posedge clk) disable iff (!nRST)
        start && !busy |-> ##RUN_CYCLES (done && !busy))
        else begin
            protocol_errors++;
            $display("done did not arrive %0d cycles after start with busy low", RUN_CYCLES);
        end

    a_done_width: assert property (@(posedge clk) disable iff (!nRST) done |=> !done)
        else begin
            protocol_errors++;
            $display("done stayed high for more than one cycle");
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic systolic_pkg::elem_t next_elem();
        rng_state = xorshift32(rng_state);
        return rng_state[31:16];
    endfunction

    function automatic systolic_pkg::row_t random_row();
        systolic_pkg::row_t r;
        for (int i = 0; i < N; i++) begin
            r[i] = next_elem();
        end
        return r;
    endfunction

    // C = A * W + P, every step wrapping at 16 bits
    function automatic void compute_expected();
        systolic_pkg::elem_t acc;
        for (int k = 0; k < N; k++) begin
            for (int c = 0; c < N; c++) begin
                acc = p_mat[k][c];
                for (int r = 0; r < N; r++) begin
                    acc = acc + a_mat[k][r] * w_mat[r][c];
                end
                c_mat[k][c] = acc;
            end
        end
    endfunction

    function automatic void fill_matrices(input bit new_weights, input bit all_ones);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_mat[i][j] = all_ones ? 16'hFFFF : next_elem();
                p_mat[i][j] = all_ones ? 16'hFFFF : next_elem();
                if (new_weights) begin
                    w_mat[i][j] = all_ones ? 16'hFFFF : next_elem();
                end
            end
        end
    endfunction

    task automatic load_row(input systolic_pkg::load_kind_t kind, input int row,
                            input systolic_pkg::row_t data);
        @(negedge clk);
        mem_load.load = 1'b1;
        mem_load.kind = kind;
        mem_load.row  = IDX_W'(row);
        mem_load.data = data;
        @(negedge clk);
        mem_load = '0;
    endtask

    task automatic load_weights();
        systolic_pkg::row_t data;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                data[c] = w_mat[r][c];
            end
            load_row(systolic_pkg::LOAD_WEIGHT, r, data);
        end
    endtask

    // Input row r is column r of A, partial row c is column c of P
    task automatic load_columns();
        systolic_pkg::row_t data;
        for (int j = 0; j < N; j++) begin
            for (int k = 0; k < N; k++) begin
                data[k] = a_mat[k][j];
            end
            load_row(systolic_pkg::LOAD_INPUT, j, data);
            for (int k = 0; k < N; k++) begin
                data[k] = p_mat[k][j];
            end
            load_row(systolic_pkg::LOAD_PARTIAL, j, data);
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1 && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            protocol_errors++;
            $display("Timed out waiting for done after %0d cycles", DONE_LIMIT);
        end else begin
            @(negedge clk);
            assert (!busy && !done) else begin
                protocol_errors++;
                $display("Engine still active in the cycle after done");
            end
        end
    endtask

    task automatic check_results();
        systolic_pkg::row_t expected_row;
        for (int row = 0; row < N; row++) begin
            @(negedge clk);
            result_row = IDX_W'(row);
            for (int c = 0; c < N; c++) begin
                expected_row[c] = c_mat[row][c];
            end
            @(posedge clk);
            row_reads++;
            assert (result_data === expected_row) else begin
                mismatch_errors++;
                $display("Mismatch: result_data row %0d got %h expected %h",
                         row, result_data, expected_row);
            end
        end
    endtask

    task automatic run_and_check();
        compute_expected();
        pulse_start();
        wait_done();
        check_results();
    endtask

    initial begin
        nRST            = 1'b0;
        start           = 1'b0;
        mem_load        = '0;
        result_row      = '0;
        rng_state       = 32'h7b9725dc;
        mismatch_errors = 0;
        protocol_errors = 0;
        row_reads       = 0;
        a_mat           = '{default: '0};
        w_mat           = '{default: '0};
        p_mat           = '{default: '0};
        repeat (RESET_CYCLES) @(negedge clk);
        nRST = 1'b1;

        // Zero matrices give an all zero result buffer
        compute_expected();
        check_results();

        // Identity weights turn the product into A + P
        fill_matrices(1'b0, 1'b0);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                w_mat[r][c] = (r == c) ? 16'd1 : 16'd0;
            end
        end
        load_weights();
        load_columns();
        run_and_check();

        repeat (3) begin
            fill_matrices(1'b1, 1'b0);
            load_weights();
            load_columns();
            run_and_check();
        end

        // Every product and sum overflows
        fill_matrices(1'b1, 1'b1);
        load_weights();
        load_columns();
        run_and_check();

        // Loads and a second start during the run must be dropped
        fill_matrices(1'b1, 1'b0);
        load_weights();
        load_columns();
        compute_expected();
        pulse_start();
        load_row(systolic_pkg::LOAD_WEIGHT, 1, random_row());
        load_row(systolic_pkg::LOAD_INPUT, 2, random_row());
        load_row(systolic_pkg::LOAD_PARTIAL, 3, random_row());
        pulse_start();
        wait_done();
        check_results();

        // New A and P against the weights already in the grid
        fill_matrices(1'b0, 1'b0);
        load_columns();
        run_and_check();

        @(negedge clk);
        $display("Checks finished: %0d row reads, %0d mismatches, %0d protocol errors",
                 row_reads, mismatch_errors, protocol_errors);
        if (mismatch_errors == 0 && protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- logic/systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
    input  logic                               clk,
    input  logic                               nRST,
    input  systolic_pkg::mem_load_t            mem_load,
    input  logic                               start,
    input  logic [systolic_pkg::ROW_IDX_W-1:0] result_row,
    output logic                               busy,
    output logic                               done,
    output systolic_pkg::row_t                 result_data
);
    logic [systolic_pkg::ARRAY_DIM-1:0] weight_load;
    logic [systolic_pkg::ARRAY_DIM-1:0] input_load;
    logic [systolic_pkg::ARRAY_DIM-1:0] ps_load;
    systolic_pkg::row_t                 load_data;
    systolic_pkg::run_ctrl_t            ctrl;

    // One activation per grid row, one partial per grid column
    systolic_pkg::row_t                 activations;
    systolic_pkg::row_t                 partials;
    systolic_pkg::row_t                 column_sums;

    array_control u_array_control (
        .clk         (clk),
        .nRST        (nRST),
        .mem_load    (mem_load),
        .start       (start),
        .weight_load (weight_load),
        .input_load  (input_load),
        .ps_load     (ps_load),
        .load_data   (load_data),
        .ctrl        (ctrl),
        .busy        (busy),
        .done        (done)
    );

    for (genvar i = 0; i < systolic_pkg::ARRAY_DIM; i++) begin : g_fifo
        // FIFO i carries column i of A
        input_skew_fifo u_input_skew_fifo (
            .clk        (clk),
            .nRST       (nRST),
            .load       (input_load[i]),
            .load_data  (load_data),
            .shift      (ctrl.input_shift[i]),
            .activation (activations[i])
        );

        // and this one column i of P
        partial_sum_fifo u_partial_sum_fifo (
            .clk       (clk),
            .nRST      (nRST),
            .load      (ps_load[i]),
            .load_data (load_data),
            .shift     (ctrl.ps_shift[i]),
            .partial   (partials[i])
        );
    end

    mac_grid u_mac_grid (
        .clk         (clk),
        .nRST        (nRST),
        .weight_load (weight_load),
        .weight_data (load_data),
        .activations (activations),
        .clear       (ctrl.mac_clear),
        .enable      (ctrl.mac_enable),
        .column_sums (column_sums)
    );

    result_stage u_result_stage (
        .clk         (clk),
        .nRST        (nRST),
        .partials    (partials),
        .column_sums (column_sums),
        .write       (ctrl.result_write),
        .write_col   (ctrl.result_col),
        .result_row  (result_row),
        .result_data (result_data)
    );

endmodule

//--- logic/array_control.sv
`timescale 1ns/1ps

module array_control (
    input  logic                               clk,
    input  logic                               nRST,
    input  systolic_pkg::mem_load_t            mem_load,
    input  logic                               start,
    output logic [systolic_pkg::ARRAY_DIM-1:0] weight_load,
    output logic [systolic_pkg::ARRAY_DIM-1:0] input_load,
    output logic [systolic_pkg::ARRAY_DIM-1:0] ps_load,
    output systolic_pkg::row_t                 load_data,
    output systolic_pkg::run_ctrl_t            ctrl,
    output logic                               busy,
    output logic                               done
);
    // Counts busy cycles, 0 is the clear cycle
    logic [$clog2(systolic_pkg::RUN_CYCLES)-1:0] cnt;
    logic [$clog2(systolic_pkg::RUN_CYCLES)-1:0] out_idx;
    logic                                        load_ok;

    // Matrices are frozen for the whole run
    assign load_ok   = mem_load.load && !busy;
    assign load_data = mem_load.data;

    always_comb begin
        weight_load = '0;
        input_load  = '0;
        ps_load     = '0;
        if (load_ok) begin
            case (mem_load.kind)
                systolic_pkg::LOAD_WEIGHT:  weight_load[mem_load.row] = 1'b1;
                systolic_pkg::LOAD_INPUT:   input_load[mem_load.row]  = 1'b1;
                systolic_pkg::LOAD_PARTIAL: ps_load[mem_load.row]     = 1'b1;
                default: ;
            endcase
        end
    end

    // Start cycle plus busy cycles 0 to RUN_CYCLES-2 puts done at RUN_CYCLES
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    cnt  <= '0;
                end
            end else if (int'(cnt) == systolic_pkg::RUN_CYCLES - 2) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Column 0 output leaves the grid ARRAY_DIM counts into the run
    assign out_idx = cnt - ($bits(cnt))'(systolic_pkg::ARRAY_DIM);

    always_comb begin
        ctrl = '0;
        if (busy) begin
            for (int i = 0; i < systolic_pkg::ARRAY_DIM; i++) begin
                // Row i enters the grid i cycles after row 0
                ctrl.input_shift[i] = (int'(cnt) > i) &&
                                      (int'(cnt) <= i + systolic_pkg::ARRAY_DIM);
                // Partial for column i follows that column's sum exit
                ctrl.ps_shift[i]    = (int'(cnt) >= i + systolic_pkg::ARRAY_DIM) &&
                                      (int'(cnt) < i + 2 * systolic_pkg::ARRAY_DIM);
            end
            ctrl.mac_clear    = (cnt == '0);
            ctrl.mac_enable   = (cnt != '0);
            ctrl.result_write = (int'(cnt) >= systolic_pkg::ARRAY_DIM) &&
                                (int'(cnt) < 2 * systolic_pkg::ARRAY_DIM);
            ctrl.result_col   = out_idx[systolic_pkg::ROW_IDX_W-1:0];
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!nRST)
        done |=> !done);

    // The last partial column drains in the final busy cycle
    a_shift_in_run: assert property (@(posedge clk) disable iff (!nRST)
        done |-> $past(ctrl.ps_shift[systolic_pkg::ARRAY_DIM-1]));

endmodule

//--- logic/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic                               clk,
    input  logic                               nRST,
    input  systolic_pkg::row_t                 partials,
    input  systolic_pkg::row_t                 column_sums,
    input  logic                               write,
    input  logic [systolic_pkg::ROW_IDX_W-1:0] write_col,
    input  logic [systolic_pkg::ROW_IDX_W-1:0] result_row,
    output systolic_pkg::row_t                 result_data
);
    systolic_pkg::row_t                 result_q [systolic_pkg::ARRAY_DIM];
    systolic_pkg::row_t                 total;
    // Per column write tracker, columns start one cycle apart
    logic [systolic_pkg::ARRAY_DIM-1:0] col_active;
    logic [systolic_pkg::ROW_IDX_W-1:0] col_row [systolic_pkg::ARRAY_DIM];

    always_comb begin
        for (int c = 0; c < systolic_pkg::ARRAY_DIM; c++) begin
            total[c] = column_sums[c] + partials[c];
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            result_q   <= '{default: '0};
            col_active <= '0;
            col_row    <= '{default: '0};
        end else begin
            for (int c = 0; c < systolic_pkg::ARRAY_DIM; c++) begin
                if (write && int'(write_col) == c) begin
                    // First row of this column is at the grid bottom now
                    result_q[0][c] <= total[c];
                    col_active[c]  <= 1'b1;
                    col_row[c]     <= 1;
                end else if (col_active[c]) begin
                    result_q[col_row[c]][c] <= total[c];
                    col_row[c]              <= col_row[c] + 1'b1;
                    if (int'(col_row[c]) == systolic_pkg::ARRAY_DIM - 1) begin
                        col_active[c] <= 1'b0;
                    end
                end
            end
        end
    end

    assign result_data = result_q[result_row];

    a_write_col_known: assert property (@(posedge clk) disable iff (!nRST)
        write |-> !$isunknown(write_col));

endmodule

//--- logic/mac_grid.sv
`timescale 1ns/1ps

module mac_grid (
    input  logic                               clk,
    input  logic                               nRST,
    input  logic [systolic_pkg::ARRAY_DIM-1:0] weight_load,
    input  systolic_pkg::row_t                 weight_data,
    input  systolic_pkg::row_t                 activations,
    input  logic                               clear,
    input  logic                               enable,
    output systolic_pkg::row_t                 column_sums
);
    localparam int N = systolic_pkg::ARRAY_DIM;

    systolic_pkg::row_t  weight_q [N];
    // Activation moving right out of each cell but the last column
    systolic_pkg::elem_t act_q    [N][N-1];
    // Running sums between grid rows
    systolic_pkg::elem_t sum_q    [N-1][N];
    systolic_pkg::elem_t act_in   [N][N];
    systolic_pkg::elem_t cell_sum [N][N];

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            weight_q <= '{default: '0};
        end else begin
            for (int r = 0; r < N; r++) begin
                if (weight_load[r]) begin
                    weight_q[r] <= weight_data;
                end
            end
        end
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            if (c == 0) begin : g_left
                assign act_in[r][c] = activations[r];
            end else begin : g_inner
                assign act_in[r][c] = act_q[r][c-1];
            end
            if (r == 0) begin : g_top
                assign cell_sum[r][c] = act_in[r][c] * weight_q[r][c];
            end else begin : g_below
                assign cell_sum[r][c] = sum_q[r-1][c] + act_in[r][c] * weight_q[r][c];
            end
        end
    end

    // Bottom row sums leave the grid without another register
    for (genvar c = 0; c < N; c++) begin : g_out
        assign column_sums[c] = cell_sum[N-1][c];
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            act_q <= '{default: '0};
            sum_q <= '{default: '0};
        end else if (enable) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N - 1; c++) begin
                    act_q[r][c] <= act_in[r][c];
                end
            end
            for (int r = 0; r < N - 1; r++) begin
                for (int c = 0; c < N; c++) begin
                    sum_q[r][c] <= cell_sum[r][c];
                end
            end
        end
    end

endmodule

//--- logic/partial_sum_fifo.sv
`timescale 1ns/1ps

module partial_sum_fifo (
    input  logic                clk,
    input  logic                nRST,
    input  logic                load,
    input  systolic_pkg::row_t  load_data,
    input  logic                shift,
    output systolic_pkg::elem_t partial
);
    // Lane k is P[k][c], released in result row order
    systolic_pkg::row_t lanes_q;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            lanes_q <= '0;
        end else if (load) begin
            lanes_q <= load_data;
        end else if (shift) begin
            for (int k = 0; k < systolic_pkg::ARRAY_DIM - 1; k++) begin
                lanes_q[k] <= lanes_q[k + 1];
            end
            lanes_q[systolic_pkg::ARRAY_DIM-1] <= '0;
        end
    end

    assign partial = lanes_q[0];

    // Loads are only taken outside a run, shifts only inside one
    a_no_load_shift: assert property (@(posedge clk) disable iff (!nRST)
        !(load && shift));

endmodule

//--- logic/input_skew_fifo.sv
`timescale 1ns/1ps

module input_skew_fifo (
    input  logic                clk,
    input  logic                nRST,
    input  logic                load,
    input  systolic_pkg::row_t  load_data,
    input  logic                shift,
    output systolic_pkg::elem_t activation
);
    // Lane 0 is the next activation into the grid
    logic [systolic_pkg::ROW_W-1:0] lanes_q;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            lanes_q <= '0;
        end else if (load) begin
            lanes_q <= load_data;
        end else if (shift) begin
            // Zero fill from the top so the wavefront drains clean
            lanes_q <= {
                {systolic_pkg::DATA_W{1'b0}},
                lanes_q[systolic_pkg::ROW_W-1:systolic_pkg::DATA_W]
            };
        end
    end

    assign activation = lanes_q[systolic_pkg::DATA_W-1:0];

endmodule

//--- logic/systolic_pkg.sv
package systolic_pkg;

    // Array geometry and element width
    localparam int ARRAY_DIM  = 4;
    localparam int DATA_W     = 16;
    localparam int ROW_W      = ARRAY_DIM * DATA_W;
    localparam int ROW_IDX_W  = $clog2(ARRAY_DIM);

    // Start cycle, clear cycle, skew fill and drain of the grid
    localparam int RUN_CYCLES = 3 * ARRAY_DIM;

    typedef logic [DATA_W-1:0] elem_t;

    // Lane 0 sits in the low bits
    typedef elem_t [ARRAY_DIM-1:0] row_t;

    typedef enum logic [1:0] {
        LOAD_WEIGHT,
        LOAD_INPUT,
        LOAD_PARTIAL
    } load_kind_t;

    // One memory-side write of a full row
    typedef struct packed {
        logic                 load;
        load_kind_t           kind;
        logic [ROW_IDX_W-1:0] row;
        row_t                 data;
    } mem_load_t;

    // Strobes from the control unit into the datapath
    typedef struct packed {
        logic [ARRAY_DIM-1:0] input_shift;
        logic [ARRAY_DIM-1:0] ps_shift;
        logic                 mac_clear;
        logic                 mac_enable;
        logic [ROW_IDX_W-1:0] result_col;
        logic                 result_write;
    } run_ctrl_t;

endpackage
